// File: files.f
rtl/tank_pkg.sv
rtl/tank_motion.sv
rtl/shell_ctrl.sv
rtl/playfield_zones.sv
rtl/pixel_mux.sv
rtl/pixel_gen.sv
verif/pixel_checker.sv
verif/tb_pixel_gen.sv

// File: rtl/pixel_gen.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_gen import tank_pkg::*; #(
    parameter int tank_velocity  = 2,
    parameter int shell_velocity = 8
) (
    input  wire logic   clk_50MHz,
    input  wire logic   reset,
    input  wire pad_t   pad,
    input  wire logic   video_on,
    input  wire coord_t x,
    input  wire coord_t y,
    output rgb_t        rgb
);

    logic        refresh_tick;
    tank_pos_t   tank_pos;
    facing_t     facing;
    coord_t      shell_x;
    coord_t      shell_y;
    zone_flags_t zones;

    // frame tick, tank position and facing
    tank_motion #(
        .tank_velocity (tank_velocity)
    ) u_tank_motion (
        .clk_50MHz    (clk_50MHz),
        .reset        (reset),
        .pad          (pad),
        .x            (x),
        .y            (y),
        .refresh_tick (refresh_tick),
        .tank_pos     (tank_pos),
        .facing       (facing)
    );

    // player shell rides on the tank until fired
    shell_ctrl #(
        .shell_velocity (shell_velocity)
    ) u_shell_ctrl (
        .clk_50MHz    (clk_50MHz),
        .reset        (reset),
        .refresh_tick (refresh_tick),
        .shot         (pad.shot),
        .tank_pos     (tank_pos),
        .facing       (facing),
        .shell_x      (shell_x),
        .shell_y      (shell_y)
    );

    // background bands
    playfield_zones u_playfield_zones (
        .x     (x),
        .y     (y),
        .zones (zones)
    );

    pixel_mux u_pixel_mux (
        .video_on (video_on),
        .x        (x),
        .y        (y),
        .tank_pos (tank_pos),
        .shell_x  (shell_x),
        .shell_y  (shell_y),
        .zones    (zones),
        .rgb      (rgb)
    );

endmodule

`default_nettype wire

// File: rtl/pixel_mux.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_mux import tank_pkg::*; (
    input  wire logic        video_on,
    input  wire coord_t      x,
    input  wire coord_t      y,
    input  wire tank_pos_t   tank_pos,
    input  wire coord_t      shell_x,
    input  wire coord_t      shell_y,
    input  wire zone_flags_t zones,
    output rgb_t             rgb
);

    logic tank_on;
    logic shell_on;

    // solid square, no sprite
    assign tank_on = (x >= tank_pos.x) && (x <= tank_pos.x + tank_size - 10'd1)
                     && (y >= tank_pos.y) && (y <= tank_pos.y + tank_size - 10'd1);

    assign shell_on = (x >= shell_x) && (x <= shell_x + shell_size - 10'd1)
                      && (y >= shell_y) && (y <= shell_y + shell_size - 10'd1);

    // tank over shell over background
    always_comb begin
        if (!video_on) begin
            rgb = colour_black;
        end else if (tank_on) begin
            rgb = colour_green;
        end else if (shell_on) begin
            rgb = colour_red;
        end else if (zones.upper_band) begin
            rgb = colour_blue;
        end else if (zones.lower_band || zones.upper_road) begin
            rgb = colour_black;
        end else if (zones.street || zones.water) begin
            rgb = colour_yellow;
        end else begin
            // walls and border
            rgb = colour_black;
        end
    end

endmodule

`default_nettype wire

// File: rtl/playfield_zones.sv
`timescale 1ns/1ns
`default_nettype none

module playfield_zones import tank_pkg::*; (
    input  wire coord_t x,
    input  wire coord_t y,
    output zone_flags_t zones
);

    logic in_cols;

    // board columns, side walls excluded
    assign in_cols = (x >= zone_x_left) && (x <= zone_x_right);

    // road strip under the top edge
    assign zones.upper_road = in_cols && (y >= road_top) && (y < water_top);

    // upper half of the board
    assign zones.water = in_cols && (y >= water_top) && (y < band_top);

    // river band across the middle
    assign zones.upper_band = in_cols && (y >= band_top) && (y < street_top);

    // lower half, where the tank starts
    assign zones.street = in_cols && (y >= street_top) && (y < lower_top);

    // strip along the bottom wall
    assign zones.lower_band = in_cols && (y >= lower_top) && (y < lower_end);

endmodule

`default_nettype wire

// File: rtl/shell_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module shell_ctrl import tank_pkg::*; #(
    parameter int shell_velocity = 8
) (
    input  wire logic      clk_50MHz,
    input  wire logic      reset,
    input  wire logic      refresh_tick,
    input  wire logic      shot,
    input  wire tank_pos_t tank_pos,
    input  wire facing_t   facing,
    output coord_t         shell_x,
    output coord_t         shell_y
);

    localparam coord_t shell_step = coord_t'(shell_velocity);

    shell_state_t state;
    facing_t      shell_dir;

    // position after one flight step
    coord_t fly_x;
    coord_t fly_y;
    logic   off_board;

    always_comb begin
        fly_x = shell_x;
        fly_y = shell_y;
        case (shell_dir)
            face_up:    fly_y = shell_y - shell_step;
            face_down:  fly_y = shell_y + shell_step;
            face_left:  fly_x = shell_x - shell_step;
            face_right: fly_x = shell_x + shell_step;
        endcase
    end

    // past any edge of the board
    assign off_board = (fly_x > shell_lim_x_hi) || (fly_x < shell_lim_lo)
                       || (fly_y > shell_lim_y_hi) || (fly_y < shell_lim_lo);

    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            state     <= shell_idle;
            shell_dir <= face_up;
            shell_x   <= x_start + shell_offset;
            shell_y   <= y_start + shell_offset;
        end else if (refresh_tick) begin
            case (state)
                shell_idle: begin
                    // parked in the tank centre, pre-move tank position
                    shell_x <= tank_pos.x + shell_offset;
                    shell_y <= tank_pos.y + shell_offset;
                    if (shot) begin
                        state     <= shell_flying;
                        shell_dir <= facing;
                    end
                end
                shell_flying: begin
                    shell_x <= fly_x;
                    shell_y <= fly_y;
                    // retire, recentred on the next frame
                    if (off_board) begin
                        state <= shell_idle;
                    end
                end
                default: begin
                    state <= shell_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/tank_motion.sv
`timescale 1ns/1ns
`default_nettype none

module tank_motion import tank_pkg::*; #(
    parameter int tank_velocity = 2
) (
    input  wire logic      clk_50MHz,
    input  wire logic      reset,
    input  wire pad_t      pad,
    input  wire coord_t    x,
    input  wire coord_t    y,
    output logic           refresh_tick,
    output tank_pos_t      tank_pos,
    output facing_t        facing
);

    // step size in coordinate width
    localparam coord_t tank_step = coord_t'(tank_velocity);

    coord_t tank_left;
    coord_t tank_right;
    coord_t tank_top;
    coord_t tank_bottom;

    logic can_up;
    logic can_down;
    logic can_left;
    logic can_right;

    // one pulse per frame, first pixel of the retrace row
    assign refresh_tick = (y == refresh_row) && (x == 10'd0);

    // tank square edges
    assign tank_left   = tank_pos.x;
    assign tank_top    = tank_pos.y;
    assign tank_right  = tank_pos.x + tank_size - 10'd1;
    assign tank_bottom = tank_pos.y + tank_size - 10'd1;

    // button and room left in that direction
    assign can_up    = pad.up && (tank_top > board_top + tank_step);
    assign can_down  = pad.down && (tank_bottom < board_bottom - tank_step);
    assign can_left  = pad.left && (tank_left > board_left + tank_step - 10'd1);
    assign can_right = pad.right && (tank_right < board_right - tank_step);

    // position, one step per frame at most
    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            tank_pos.x <= x_start;
            tank_pos.y <= y_start;
        end else if (refresh_tick) begin
            // blocked direction falls through to the next button
            if (can_up) begin
                tank_pos.y <= tank_pos.y - tank_step;
            end else if (can_down) begin
                tank_pos.y <= tank_pos.y + tank_step;
            end else if (can_left) begin
                tank_pos.x <= tank_pos.x - tank_step;
            end else if (can_right) begin
                tank_pos.x <= tank_pos.x + tank_step;
            end
        end
    end

    // facing follows the pad even when the tank is blocked
    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            facing <= face_up;
        end else if (refresh_tick) begin
            if (pad.up) begin
                facing <= face_up;
            end else if (pad.down) begin
                facing <= face_down;
            end else if (pad.left) begin
                facing <= face_left;
            end else if (pad.right) begin
                facing <= face_right;
            end
            // no button, hold
        end
    end

endmodule

`default_nettype wire

// File: rtl/tank_pkg.sv
`default_nettype none

package tank_pkg;

    // one raster or object coordinate
    typedef logic [9:0] coord_t;

    // 10 bits per channel, red on top
    typedef logic [29:0] rgb_t;

    typedef enum logic [1:0] {
        face_up    = 2'b00,
        face_down  = 2'b01,
        face_left  = 2'b10,
        face_right = 2'b11
    } facing_t;

    typedef enum logic {
        shell_idle   = 1'b0,
        shell_flying = 1'b1
    } shell_state_t;

    // raw button levels
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic shot;
    } pad_t;

    // top-left corner of the tank square
    typedef struct packed {
        coord_t x;
        coord_t y;
    } tank_pos_t;

    // background bands, all inside the play columns
    typedef struct packed {
        logic upper_band;
        logic lower_band;
        logic street;
        logic upper_road;
        logic water;
    } zone_flags_t;

    localparam rgb_t colour_red    = {10'h3ff, 10'h000, 10'h000};
    localparam rgb_t colour_green  = {10'h000, 10'h3ff, 10'h000};
    localparam rgb_t colour_blue   = {10'h000, 10'h000, 10'h3ff};
    localparam rgb_t colour_yellow = {10'h3ff, 10'h3ff, 10'h000};
    localparam rgb_t colour_black  = 30'h0;

    // frame tick sits at the start of vertical retrace
    localparam coord_t refresh_row = 10'd491;
    localparam coord_t x_max       = 10'd639;
    localparam coord_t y_max       = 10'd479;

    localparam coord_t tank_size = 10'd32;
    localparam coord_t x_start   = 10'd32;
    localparam coord_t y_start   = 10'd416;

    // tank travel limits
    localparam coord_t board_left   = 10'd32;
    localparam coord_t board_right  = 10'd608;
    localparam coord_t board_top    = 10'd32;
    localparam coord_t board_bottom = 10'd448;

    localparam coord_t shell_size   = 10'd4;
    localparam coord_t shell_offset = tank_size / 2 - shell_size / 2;
    // shell is retired once it leaves this window
    localparam coord_t shell_lim_lo   = 10'd28;
    localparam coord_t shell_lim_x_hi = 10'd607;
    localparam coord_t shell_lim_y_hi = 10'd447;

    // background columns and row edges
    localparam coord_t zone_x_left  = 10'd32;
    localparam coord_t zone_x_right = 10'd607;
    localparam coord_t road_top     = 10'd31;
    localparam coord_t water_top    = 10'd68;
    localparam coord_t band_top     = 10'd228;
    localparam coord_t street_top   = 10'd260;
    localparam coord_t lower_top    = 10'd420;
    localparam coord_t lower_end    = 10'd452;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the pixel generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_pixel_gen \
    -Mdir obj_dir -o tb_pixel_gen > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_pixel_gen > sim.log 2>&1 || { cat sim.log; echo "simulation failed to run"; exit 1; }
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

// File: verif/pixel_checker.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_checker import tank_pkg::*; (
    input  wire logic       clk_50MHz,
    input  wire rgb_t       rgb,
    input  wire logic       check_en,
    input  wire rgb_t       expected,
    input  wire coord_t     probe_x,
    input  wire coord_t     probe_y,
    input  wire logic       test_end,
    input  wire logic [7:0] test_id,
    output int              checks,
    output int              errors
);

    int check_count = 0;
    int error_count = 0;
    int test_checks = 0;
    int test_errors = 0;

    assign checks = check_count;
    assign errors = error_count;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1: return "after reset";
            8'd2: return "movement";
            8'd3: return "bounds";
            8'd4: return "shell";
            8'd5: return "zones and blanking";
            default: return "unknown";
        endcase
    endfunction

    // rgb is settled here, inputs change on the falling edge
    always @(posedge clk_50MHz) begin
        if (check_en) begin
            check_count <= check_count + 1;
            test_checks <= test_checks + 1;
            if (rgb !== expected) begin
                error_count <= error_count + 1;
                test_errors <= test_errors + 1;
                $display("[ERROR] rgb at x=%0d y=%0d: expected 30'h%h, got 30'h%h",
                         probe_x, probe_y, expected, rgb);
            end
        end
        // per-test summary
        if (test_end) begin
            $display("test %0d (%s): %0d checks, %0d errors", test_id, test_name(test_id),
                     test_checks, test_errors);
            test_checks <= 0;
            test_errors <= 0;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_pixel_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pixel_gen import tank_pkg::*; ();

    localparam int tank_step  = 2;
    localparam int shell_step = 8;
    // probes per refresh, plus slack for the shell flight and finish cycles
    localparam int planned_cycles = 6 + 40 * 9 + 600 * 9 + 100 * 3 + 6 + 300 + 5 * 2 + 20;
    localparam int timeout_cycles = 2 * planned_cycles;

    logic        clk_50MHz;
    logic        reset;
    pad_t        pad;
    logic        video_on;
    coord_t      x;
    coord_t      y;
    rgb_t        rgb;
    logic        check_en;
    rgb_t        expected;
    logic        test_end;
    logic [7:0]  test_id;
    int          checks;
    int          errors;
    int          cycle_count = 0;
    logic [31:0] rng;

    // reference model state
    int      m_tank_x;
    int      m_tank_y;
    facing_t m_facing;
    logic    m_flying;
    facing_t m_dir;
    int      m_shell_x;
    int      m_shell_y;

    pixel_gen #(
        .tank_velocity  (tank_step),
        .shell_velocity (shell_step)
    ) u_dut (
        .clk_50MHz (clk_50MHz),
        .reset     (reset),
        .pad       (pad),
        .video_on  (video_on),
        .x         (x),
        .y         (y),
        .rgb       (rgb)
    );

    pixel_checker u_checker (
        .clk_50MHz (clk_50MHz),
        .rgb       (rgb),
        .check_en  (check_en),
        .expected  (expected),
        .probe_x   (x),
        .probe_y   (y),
        .test_end  (test_end),
        .test_id   (test_id),
        .checks    (checks),
        .errors    (errors)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // background only, play columns 32..607
    function automatic rgb_t zone_colour(input int px, input int py);
        if (px < 32 || px > 607) return colour_black;
        if (py >= 228 && py < 260) return colour_blue;
        // water above, street below the band
        if (py >= 68 && py < 420) return colour_yellow;
        return colour_black;
    endfunction

    function automatic rgb_t expected_rgb(input int px, input int py, input logic vid);
        if (!vid) return colour_black;
        if (px >= m_tank_x && px <= m_tank_x + 31 && py >= m_tank_y && py <= m_tank_y + 31)
            return colour_green;
        if (px >= m_shell_x && px <= m_shell_x + 3 && py >= m_shell_y && py <= m_shell_y + 3)
            return colour_red;
        return zone_colour(px, py);
    endfunction

    // one frame of the reference model
    function automatic void model_refresh(input pad_t p);
        int nx;
        int ny;
        // shell sees the tank from before this frame's move
        if (!m_flying) begin
            m_shell_x = m_tank_x + 14;
            m_shell_y = m_tank_y + 14;
            if (p.shot) begin
                m_flying = 1'b1;
                m_dir = m_facing;
            end
        end else begin
            nx = m_shell_x;
            ny = m_shell_y;
            case (m_dir)
                face_up:    ny = ny - shell_step;
                face_down:  ny = ny + shell_step;
                face_left:  nx = nx - shell_step;
                face_right: nx = nx + shell_step;
            endcase
            m_shell_x = nx;
            m_shell_y = ny;
            if (nx > 607 || nx < 28 || ny > 447 || ny < 28) m_flying = 1'b0;
        end
        // priority up, down, left, right, each with its bound
        if (p.up && m_tank_y > 32 + tank_step) m_tank_y = m_tank_y - tank_step;
        else if (p.down && m_tank_y + 31 < 448 - tank_step) m_tank_y = m_tank_y + tank_step;
        else if (p.left && m_tank_x > 32 + tank_step - 1) m_tank_x = m_tank_x - tank_step;
        else if (p.right && m_tank_x + 31 < 608 - tank_step) m_tank_x = m_tank_x + tank_step;
        if (p.up) m_facing = face_up;
        else if (p.down) m_facing = face_down;
        else if (p.left) m_facing = face_left;
        else if (p.right) m_facing = face_right;
    endfunction

    // first pixel of the retrace row for one cycle
    task automatic drive_refresh(input pad_t p);
        @(negedge clk_50MHz);
        check_en = 1'b0;
        pad = p;
        x = 10'd0;
        y = 10'd491;
        model_refresh(p);
    endtask

    task automatic probe_pixel(input int px, input int py, input logic vid, input rgb_t want);
        @(negedge clk_50MHz);
        x = coord_t'(px);
        y = coord_t'(py);
        video_on = vid;
        expected = want;
        check_en = 1'b1;
    endtask

    task automatic probe_model(input int px, input int py);
        probe_pixel(px, py, 1'b1, expected_rgb(px, py, 1'b1));
    endtask

    // four corners and one pixel just outside each
    task automatic probe_tank_edges();
        probe_model(m_tank_x, m_tank_y);
        probe_model(m_tank_x + 31, m_tank_y);
        probe_model(m_tank_x, m_tank_y + 31);
        probe_model(m_tank_x + 31, m_tank_y + 31);
        probe_model(m_tank_x - 1, m_tank_y);
        probe_model(m_tank_x + 32, m_tank_y + 31);
        probe_model(m_tank_x, m_tank_y - 1);
        probe_model(m_tank_x + 31, m_tank_y + 32);
    endtask

    task automatic finish_test(input int id);
        @(negedge clk_50MHz);
        check_en = 1'b0;
        test_id = 8'(id);
        test_end = 1'b1;
        @(negedge clk_50MHz);
        test_end = 1'b0;
    endtask

    initial begin
        pad_t p;
        int   n;
        int   px;
        int   py;
        int   exit_x;
        int   exit_y;
        clk_50MHz = 1'b0;
        reset = 1'b0;
        pad = '0;
        video_on = 1'b0;
        x = 10'd0;
        y = 10'd0;
        check_en = 1'b0;
        expected = colour_black;
        test_end = 1'b0;
        test_id = 8'd0;
        rng = 32'hea65_63f4;
        m_tank_x = 32;
        m_tank_y = 416;
        m_facing = face_up;
        m_flying = 1'b0;
        m_dir = face_up;
        m_shell_x = 46;
        m_shell_y = 430;
        repeat (2) @(posedge clk_50MHz);
        @(negedge clk_50MHz);
        reset = 1'b1;

        // fixed colours straight after reset
        probe_pixel(32, 416, 1'b1, colour_green);
        probe_pixel(31, 430, 1'b1, colour_black);
        probe_pixel(100, 300, 1'b1, colour_yellow);
        probe_pixel(100, 240, 1'b1, colour_blue);
        finish_test(1);

        // random buttons, shot included
        repeat (40) begin
            rng = xorshift32(rng);
            drive_refresh(pad_t'(rng[4:0]));
            probe_tank_edges();
        end
        finish_test(2);

        // push into the left wall, then the top wall
        p = '0;
        p.left = 1'b1;
        repeat (300) begin
            drive_refresh(p);
            probe_tank_edges();
        end
        p = '0;
        p.up = 1'b1;
        repeat (300) begin
            drive_refresh(p);
            probe_tank_edges();
        end
        finish_test(3);

        // face right, fire once, follow the flight
        p = '0;
        p.right = 1'b1;
        drive_refresh(p);
        p = '0;
        p.shot = 1'b1;
        drive_refresh(p);
        n = 0;
        while (m_flying && n < 100) begin
            drive_refresh('0);
            probe_model(m_shell_x, m_shell_y);
            probe_model(m_shell_x - 1, m_shell_y + 1);
            n = n + 1;
        end
        exit_x = m_shell_x;
        exit_y = m_shell_y;
        // recentred on the tank one frame later, nothing one step further out
        drive_refresh('0);
        probe_model(exit_x, exit_y);
        probe_model(exit_x + shell_step, exit_y);
        probe_model(m_shell_x, m_shell_y);
        finish_test(4);

        // background bands, then blanking
        repeat (200) begin
            rng = xorshift32(rng);
            px = int'(rng % 32'd640);
            rng = xorshift32(rng);
            py = int'(rng % 32'd480);
            probe_model(px, py);
        end
        repeat (100) begin
            rng = xorshift32(rng);
            px = int'(rng % 32'd640);
            rng = xorshift32(rng);
            py = int'(rng % 32'd480);
            probe_pixel(px, py, 1'b0, expected_rgb(px, py, 1'b0));
        end
        finish_test(5);

        repeat (2) @(negedge clk_50MHz);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // run limit
    always @(posedge clk_50MHz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire
